/* rtl/cmd_pkg.sv */
package cmd_pkg;

    // Every header word splits into an opcode and a byte count
    localparam int OP_POS = 28;
    localparam int OP_SIZE = 4;
    localparam int IMM_POS = 0;
    localparam int IMM_SIZE = 28;

    // Payload beats are 32-bit words, so the byte count drops its two low bits
    localparam int BEAT_SHIFT = 2;
    localparam int BEAT_WIDTH = IMM_SIZE - BEAT_SHIFT;

    // Opcode values, anything above OP_STREAM is handled like a NOP
    localparam logic [OP_SIZE-1:0] OP_NOP = OP_SIZE'(0);
    localparam logic [OP_SIZE-1:0] OP_STORE = OP_SIZE'(1);
    localparam logic [OP_SIZE-1:0] OP_LOAD = OP_SIZE'(2);
    localparam logic [OP_SIZE-1:0] OP_MEMSET = OP_SIZE'(3);
    localparam logic [OP_SIZE-1:0] OP_STREAM = OP_SIZE'(4);

endpackage

/* rtl/mem_pkg.sv */
package mem_pkg;

    // Width of a memory word and of both streams
    localparam int DATA_WIDTH = 32;

    // Word interleaving: the low address bits pick the bank, the rest the row
    localparam int NUM_BANKS = 4;
    localparam int BANK_SEL_WIDTH = 2;
    localparam int BANK_DEPTH = 64;
    localparam int ROW_WIDTH = 6;

    // 256 words in total, addresses wrap around
    localparam int WORD_ADDR_WIDTH = 8;

endpackage

/* rtl/scratch_bank.sv */
`timescale 1ns/1ps

module scratch_bank
(
    input  logic                           aclk,
    input  logic                           wr_en,
    input  logic [mem_pkg::ROW_WIDTH-1:0]  wr_row,
    input  logic [mem_pkg::DATA_WIDTH-1:0] wr_data,
    input  logic [mem_pkg::ROW_WIDTH-1:0]  rd_row,
    output logic [mem_pkg::DATA_WIDTH-1:0] rd_data
);
    logic [mem_pkg::DATA_WIDTH-1:0] mem [mem_pkg::BANK_DEPTH];

    // The read port samples every cycle and returns the old word on a collision
    always_ff @(posedge aclk)
    begin
        if (wr_en)
        begin
            mem[wr_row] <= wr_data;
        end
        rd_data <= mem[rd_row];
    end

endmodule

/* rtl/cmd_parser.sv */
`timescale 1ns/1ps

module cmd_parser
(
    input  logic                                aclk,
    input  logic                                resetn,
    input  logic                                s_axis_tvalid,
    output logic                                s_axis_tready,
    input  logic [mem_pkg::DATA_WIDTH-1:0]      s_axis_tdata,
    input  logic                                s_axis_tlast,
    input  logic                                credit,
    output logic [mem_pkg::NUM_BANKS-1:0]       wr_en,
    output logic [mem_pkg::ROW_WIDTH-1:0]       wr_row,
    output logic [mem_pkg::DATA_WIDTH-1:0]      wr_data,
    output logic [mem_pkg::ROW_WIDTH-1:0]       rd_row,
    output logic                                item_strobe,
    output logic                                item_from_bank,
    output logic [mem_pkg::BANK_SEL_WIDTH-1:0]  item_bank,
    output logic [mem_pkg::DATA_WIDTH-1:0]      item_data,
    output logic                                item_last
);
    typedef enum logic [2:0] {
        S_IDLE,
        S_HEADER,
        S_ADDR,
        S_FILL,
        S_STORE,
        S_LOAD,
        S_MEMSET,
        S_STREAM
    } state_t;

    state_t                               state;
    logic [cmd_pkg::OP_SIZE-1:0]          op;
    logic [cmd_pkg::BEAT_WIDTH-1:0]       beats;
    logic [mem_pkg::WORD_ADDR_WIDTH-1:0]  addr;
    logic [mem_pkg::DATA_WIDTH-1:0]       fill;
    logic [cmd_pkg::OP_SIZE-1:0]          hdr_op;
    logic [cmd_pkg::BEAT_WIDTH-1:0]       hdr_beats;
    logic                                 accept;
    logic                                 beat_step;
    logic                                 last_beat;
    logic                                 wr_active;

    assign hdr_op = s_axis_tdata[cmd_pkg::OP_POS +: cmd_pkg::OP_SIZE];
    assign hdr_beats = s_axis_tdata[cmd_pkg::IMM_POS + cmd_pkg::BEAT_SHIFT +: cmd_pkg::BEAT_WIDTH];

    always_comb
    begin
        case (state)
            S_HEADER, S_ADDR, S_FILL, S_STORE: s_axis_tready = 1'b1;
            // A pass-through beat needs room in the output buffer
            S_STREAM: s_axis_tready = credit;
            default: s_axis_tready = 1'b0;
        endcase
    end

    assign accept = s_axis_tvalid && s_axis_tready;

    // One payload beat is handled in every cycle where beat_step is high
    always_comb
    begin
        case (state)
            S_STORE, S_STREAM: beat_step = accept;
            S_MEMSET: beat_step = 1'b1;
            S_LOAD: beat_step = credit;
            default: beat_step = 1'b0;
        endcase
    end

    assign last_beat = (beats == cmd_pkg::BEAT_WIDTH'(1));
    assign wr_active = beat_step && ((state == S_STORE) || (state == S_MEMSET));

    assign wr_en = wr_active ? ({{(mem_pkg::NUM_BANKS - 1){1'b0}}, 1'b1}
                                << addr[mem_pkg::BANK_SEL_WIDTH-1:0])
                             : '0;
    assign wr_row = addr[mem_pkg::BANK_SEL_WIDTH +: mem_pkg::ROW_WIDTH];
    assign wr_data = (state == S_STORE) ? s_axis_tdata : fill;
    assign rd_row = addr[mem_pkg::BANK_SEL_WIDTH +: mem_pkg::ROW_WIDTH];

    assign item_strobe = beat_step && ((state == S_LOAD) || (state == S_STREAM));
    assign item_from_bank = (state == S_LOAD);
    assign item_bank = addr[mem_pkg::BANK_SEL_WIDTH-1:0];
    assign item_data = s_axis_tdata;
    assign item_last = last_beat;

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            state <= S_IDLE;
        end
        else
        begin
            case (state)
                S_IDLE:
                begin
                    state <= S_HEADER;
                end
                S_HEADER:
                begin
                    if (accept)
                    begin
                        case (hdr_op)
                            cmd_pkg::OP_NOP: state <= S_HEADER;
                            cmd_pkg::OP_STORE, cmd_pkg::OP_LOAD, cmd_pkg::OP_MEMSET:
                                state <= S_ADDR;
                            cmd_pkg::OP_STREAM:
                                state <= (hdr_beats == '0) ? S_HEADER : S_STREAM;
                            default: state <= S_HEADER;
                        endcase
                    end
                end
                S_ADDR:
                begin
                    if (accept)
                    begin
                        // MEMSET still owes its fill word, even for a zero count
                        if (op == cmd_pkg::OP_MEMSET)
                            state <= S_FILL;
                        else if (beats == '0)
                            state <= S_HEADER;
                        else if (op == cmd_pkg::OP_STORE)
                            state <= S_STORE;
                        else
                            state <= S_LOAD;
                    end
                end
                S_FILL:
                begin
                    if (accept)
                    begin
                        state <= (beats == '0) ? S_HEADER : S_MEMSET;
                    end
                end
                default:
                begin
                    if (beat_step && last_beat)
                    begin
                        state <= S_HEADER;
                    end
                end
            endcase
        end
    end

    // Operation registers take the header, the address word and the fill word
    always_ff @(posedge aclk)
    begin
        if ((state == S_HEADER) && accept)
        begin
            op <= hdr_op;
            beats <= hdr_beats;
        end
        else if (beat_step)
        begin
            beats <= beats - 1'b1;
        end

        if ((state == S_ADDR) && accept)
            addr <= s_axis_tdata[mem_pkg::WORD_ADDR_WIDTH-1:0];
        else if (beat_step && (state != S_STREAM))
            addr <= addr + 1'b1;

        if ((state == S_FILL) && accept)
            fill <= s_axis_tdata;
    end

endmodule

/* rtl/read_merge.sv */
`timescale 1ns/1ps

module read_merge
(
    input  logic                                                aclk,
    input  logic                                                resetn,
    input  logic                                                item_strobe,
    input  logic                                                item_from_bank,
    input  logic [mem_pkg::BANK_SEL_WIDTH-1:0]                  item_bank,
    input  logic [mem_pkg::DATA_WIDTH-1:0]                      item_data,
    input  logic                                                item_last,
    input  logic [mem_pkg::NUM_BANKS*mem_pkg::DATA_WIDTH-1:0]   bank_rd_data,
    input  logic                                                m_axis_tready,
    output logic                                                credit,
    output logic                                                m_axis_tvalid,
    output logic [mem_pkg::DATA_WIDTH-1:0]                      m_axis_tdata,
    output logic                                                m_axis_tlast
);
    logic                                 s1_valid;
    logic                                 s1_from_bank;
    logic [mem_pkg::BANK_SEL_WIDTH-1:0]   s1_bank;
    logic [mem_pkg::DATA_WIDTH-1:0]       s1_data;
    logic                                 s1_last;
    logic [mem_pkg::DATA_WIDTH-1:0]       push_data;
    logic [mem_pkg::DATA_WIDTH-1:0]       buf_data [2];
    logic [1:0]                           buf_last;
    logic                                 wr_ptr;
    logic                                 rd_ptr;
    logic [1:0]                           count;
    logic [1:0]                           occupancy;
    logic                                 pop;

    // Bank data arrives one cycle after the strobe, in step with stage one
    assign push_data = s1_from_bank ? bank_rd_data[s1_bank*mem_pkg::DATA_WIDTH +: mem_pkg::DATA_WIDTH]
                                    : s1_data;

    assign pop = m_axis_tvalid && m_axis_tready;

    // Buffered entries plus the item in flight, less the one leaving now
    assign occupancy = count + {1'b0, s1_valid} - {1'b0, pop};
    assign credit = (occupancy < 2'd2);

    assign m_axis_tvalid = (count != 2'd0);
    assign m_axis_tdata = buf_data[rd_ptr];
    assign m_axis_tlast = m_axis_tvalid && buf_last[rd_ptr];

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            s1_valid <= 1'b0;
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count <= 2'd0;
        end
        else
        begin
            s1_valid <= item_strobe;
            if (s1_valid)
                wr_ptr <= ~wr_ptr;
            if (pop)
                rd_ptr <= ~rd_ptr;
            count <= occupancy;
        end
    end

    always_ff @(posedge aclk)
    begin
        s1_from_bank <= item_from_bank;
        s1_bank <= item_bank;
        s1_data <= item_data;
        s1_last <= item_last;
        if (s1_valid)
        begin
            buf_data[wr_ptr] <= push_data;
            buf_last[wr_ptr] <= s1_last;
        end
    end

endmodule

/* rtl/cmd_mem_top.sv */
`timescale 1ns/1ps

module cmd_mem_top
(
    input  logic                            aclk,
    input  logic                            resetn,
    input  logic                            s_axis_tvalid,
    output logic                            s_axis_tready,
    input  logic [mem_pkg::DATA_WIDTH-1:0]  s_axis_tdata,
    input  logic                            s_axis_tlast,
    output logic                            m_axis_tvalid,
    input  logic                            m_axis_tready,
    output logic [mem_pkg::DATA_WIDTH-1:0]  m_axis_tdata,
    output logic                            m_axis_tlast
);
    logic [mem_pkg::NUM_BANKS-1:0]                      wr_en;
    logic [mem_pkg::ROW_WIDTH-1:0]                      wr_row;
    logic [mem_pkg::DATA_WIDTH-1:0]                     wr_data;
    logic [mem_pkg::ROW_WIDTH-1:0]                      rd_row;
    logic [mem_pkg::NUM_BANKS*mem_pkg::DATA_WIDTH-1:0]  bank_rd_data;
    logic                                               item_strobe;
    logic                                               item_from_bank;
    logic [mem_pkg::BANK_SEL_WIDTH-1:0]                 item_bank;
    logic [mem_pkg::DATA_WIDTH-1:0]                     item_data;
    logic                                               item_last;
    logic                                               credit;

    cmd_parser u_parser
    (
        .aclk           (aclk),
        .resetn         (resetn),
        .s_axis_tvalid  (s_axis_tvalid),
        .s_axis_tready  (s_axis_tready),
        .s_axis_tdata   (s_axis_tdata),
        .s_axis_tlast   (s_axis_tlast),
        .credit         (credit),
        .wr_en          (wr_en),
        .wr_row         (wr_row),
        .wr_data        (wr_data),
        .rd_row         (rd_row),
        .item_strobe    (item_strobe),
        .item_from_bank (item_from_bank),
        .item_bank      (item_bank),
        .item_data      (item_data),
        .item_last      (item_last)
    );

    // All banks share the row and data lines, each has its own write enable
    for (genvar i = 0; i < mem_pkg::NUM_BANKS; i++)
    begin : g_bank
        scratch_bank u_bank
        (
            .aclk    (aclk),
            .wr_en   (wr_en[i]),
            .wr_row  (wr_row),
            .wr_data (wr_data),
            .rd_row  (rd_row),
            .rd_data (bank_rd_data[i*mem_pkg::DATA_WIDTH +: mem_pkg::DATA_WIDTH])
        );
    end

    read_merge u_merge
    (
        .aclk           (aclk),
        .resetn         (resetn),
        .item_strobe    (item_strobe),
        .item_from_bank (item_from_bank),
        .item_bank      (item_bank),
        .item_data      (item_data),
        .item_last      (item_last),
        .bank_rd_data   (bank_rd_data),
        .m_axis_tready  (m_axis_tready),
        .credit         (credit),
        .m_axis_tvalid  (m_axis_tvalid),
        .m_axis_tdata   (m_axis_tdata),
        .m_axis_tlast   (m_axis_tlast)
    );

endmodule

/* tests/cmd_mem_checker.sv */
`timescale 1ns/1ps

module cmd_mem_checker
(
    input logic                           aclk,
    input logic                           resetn,
    input logic                           m_axis_tvalid,
    input logic                           m_axis_tready,
    input logic [mem_pkg::DATA_WIDTH-1:0] m_axis_tdata,
    input logic                           m_axis_tlast,
    input logic [mem_pkg::NUM_BANKS-1:0]  wr_en,
    input logic                           item_strobe,
    input logic                           credit
);
    // Number of assertion failures seen so far
    int assert_errors = 0;

    // A reset cycle clears the output buffer
    reset_clears_valid: assert property (@(posedge aclk) !resetn |=> !m_axis_tvalid)
    else
    begin
        assert_errors++;
        $error("m_axis_tvalid high after a reset cycle");
    end

    output_held: assert property (@(posedge aclk) disable iff (!resetn)
        (m_axis_tvalid && !m_axis_tready) |=>
        (m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast)))
    else
    begin
        assert_errors++;
        $error("output stream changed while stalled");
    end

    // At most one bank is written per cycle
    single_bank_write: assert property (@(posedge aclk) disable iff (!resetn) $onehot0(wr_en))
    else
    begin
        assert_errors++;
        $error("more than one bank write enable active");
    end

    strobe_needs_credit: assert property (@(posedge aclk) disable iff (!resetn)
        item_strobe |-> credit)
    else
    begin
        assert_errors++;
        $error("item strobe issued without credit");
    end

endmodule

/* tests/tb_cmd_mem.sv */
`timescale 1ns/1ps

module tb_cmd_mem;

    localparam int TIMEOUT = 5000;
    localparam int NUM_RANDOM = 300;

    logic                           aclk;
    logic                           resetn;
    logic                           s_axis_tvalid;
    logic                           s_axis_tready;
    logic [mem_pkg::DATA_WIDTH-1:0] s_axis_tdata;
    logic                           s_axis_tlast;
    logic                           m_axis_tvalid;
    logic                           m_axis_tready;
    logic [mem_pkg::DATA_WIDTH-1:0] m_axis_tdata;
    logic                           m_axis_tlast;

    int          seed;
    int          errors;
    bit          throttle;
    bit          gaps;
    logic [31:0] model_mem [256];
    // Each expected output beat is {tlast, tdata}
    logic [32:0] expected [$];
    logic [32:0] exp_beat;

    cmd_mem_top DUT (.*);

    bind cmd_mem_top cmd_mem_checker u_checker
    (
        .aclk          (aclk),
        .resetn        (resetn),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tlast  (m_axis_tlast),
        .wr_en         (wr_en),
        .item_strobe   (item_strobe),
        .credit        (credit)
    );

    always #50 aclk = ~aclk;

    // Output back-pressure is random while throttling is on
    always @(posedge aclk)
    begin
        #1;
        if (throttle)
            m_axis_tready = (($random(seed) & 3) > 1);
        else
            m_axis_tready = 1'b1;
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp)
        begin
            errors++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic abort_run(input string reason);
        $display("Timeout: %s", reason);
        $display("Test FAILED");
        $finish;
    endtask

    // Outputs settle by the falling edge and transfer at the next rising edge
    always @(negedge aclk)
    begin
        if (resetn && m_axis_tvalid && m_axis_tready)
        begin
            if (expected.size() == 0)
            begin
                errors++;
                $display("Output beat %h arrived when no beat was expected", m_axis_tdata);
            end
            else
            begin
                exp_beat = expected.pop_front();
                compare_value("m_axis_tdata", m_axis_tdata, exp_beat[31:0]);
                compare_value("m_axis_tlast", 32'(m_axis_tlast), 32'(exp_beat[32]));
            end
        end
    end

    function automatic logic [31:0] fill_pattern(input logic [7:0] a);
        return {8'h5a, a, ~a, a ^ 8'h3c};
    endfunction

    task automatic send_word(input logic [31:0] word);
        int gap;
        int wait_cycles;
        gap = 0;
        if (gaps && (($random(seed) & 3) == 0))
            gap = 1 + ($random(seed) & 3);
        repeat (gap)
        begin
            @(posedge aclk);
            #1;
        end
        s_axis_tvalid = 1'b1;
        s_axis_tdata = word;
        // The DUT frames commands by their counts, so tlast is just noise here
        s_axis_tlast = $random(seed) & 1;
        wait_cycles = 0;
        @(negedge aclk);
        while (!s_axis_tready)
        begin
            wait_cycles++;
            if (wait_cycles > TIMEOUT)
                abort_run("a command word was never accepted");
            @(negedge aclk);
        end
        @(posedge aclk);
        #1;
        s_axis_tvalid = 1'b0;
    endtask

    // Random low bits in the byte count must be dropped by the DUT
    task automatic send_header(input logic [3:0] op, input int beats);
        logic [27:0] bytes;
        bytes = 28'(beats * 4) | 28'($random(seed) & 3);
        send_word({op, bytes});
    endtask

    task automatic store_range(input int beats, input logic [7:0] addr);
        logic [31:0] word;
        send_header(cmd_pkg::OP_STORE, beats);
        send_word({24'($random(seed)), addr});
        for (int i = 0; i < beats; i++)
        begin
            word = $random(seed);
            model_mem[addr + 8'(i)] = word;
            send_word(word);
        end
    endtask

    task automatic load_range(input int beats, input logic [7:0] addr);
        send_header(cmd_pkg::OP_LOAD, beats);
        for (int i = 0; i < beats; i++)
            expected.push_back({i == beats - 1, model_mem[addr + 8'(i)]});
        send_word({24'($random(seed)), addr});
    endtask

    task automatic memset_range(input int beats, input logic [7:0] addr, input logic [31:0] fill);
        send_header(cmd_pkg::OP_MEMSET, beats);
        send_word({24'($random(seed)), addr});
        send_word(fill);
        for (int i = 0; i < beats; i++)
            model_mem[addr + 8'(i)] = fill;
    endtask

    task automatic stream_payload(input int beats);
        logic [31:0] word;
        send_header(cmd_pkg::OP_STREAM, beats);
        for (int i = 0; i < beats; i++)
        begin
            word = $random(seed);
            expected.push_back({i == beats - 1, word});
            send_word(word);
        end
    endtask

    task automatic preload();
        send_header(cmd_pkg::OP_STORE, 256);
        send_word(32'd0);
        for (int a = 0; a < 256; a++)
        begin
            model_mem[8'(a)] = fill_pattern(8'(a));
            send_word(model_mem[8'(a)]);
        end
    endtask

    task automatic random_command();
        int sel;
        int beats;
        logic [7:0] addr;
        sel = {$random(seed)} % 16;
        beats = {$random(seed)} % 13;
        addr = 8'($random(seed));
        if (sel < 3)
            store_range(beats, addr);
        else if (sel < 6)
            load_range(beats, addr);
        else if (sel < 8)
            memset_range(beats, addr, $random(seed));
        else if (sel < 11)
            stream_payload(beats);
        else if (sel == 11)
            send_header(cmd_pkg::OP_NOP, beats);
        else
            send_header(4'(sel), beats);
    endtask

    initial
    begin
        int wait_cycles;
        seed = 32'h3b122fcd;
        errors = 0;
        throttle = 1'b0;
        gaps = 1'b0;
        aclk = 1'b0;
        resetn = 1'b0;
        s_axis_tvalid = 1'b0;
        s_axis_tdata = '0;
        s_axis_tlast = 1'b0;
        m_axis_tready = 1'b0;

        repeat (4)
        begin
            @(posedge aclk);
            #1;
            compare_value("m_axis_tvalid", 32'(m_axis_tvalid), 32'd0);
            compare_value("s_axis_tready", 32'(s_axis_tready), 32'd0);
        end
        resetn = 1'b1;
        compare_value("m_axis_tvalid", 32'(m_axis_tvalid), 32'd0);
        compare_value("s_axis_tready", 32'(s_axis_tready), 32'd0);

        preload();
        gaps = 1'b1;

        // Store and read back across the top of the address space and in the middle
        store_range(8, 8'd252);
        load_range(8, 8'd252);
        store_range(5, 8'd17);
        load_range(5, 8'd17);

        // The load reaches two words past each end of the filled range
        memset_range(6, 8'd100, 32'hdeadbeef);
        load_range(10, 8'd98);

        stream_payload(7);
        stream_payload(0);
        stream_payload(3);
        store_range(0, 8'd40);
        load_range(0, 8'd40);
        memset_range(0, 8'd40, 32'h0bad0bad);
        stream_payload(1);

        send_header(cmd_pkg::OP_NOP, 4);
        send_header(4'd9, 6);
        send_header(4'd15, 0);
        load_range(12, 8'd36);

        throttle = 1'b1;
        repeat (NUM_RANDOM)
            random_command();
        load_range(256, 8'd0);

        wait_cycles = 0;
        while (expected.size() != 0)
        begin
            @(posedge aclk);
            wait_cycles++;
            if (wait_cycles > TIMEOUT)
                abort_run("the output stream stopped with beats still expected");
        end
        // Quiet window in which any extra output beat would show up
        repeat (20) @(posedge aclk);

        $display("Errors: %0d compare, %0d assertion", errors, DUT.u_checker.assert_errors);
        if ((errors == 0) && (DUT.u_checker.assert_errors == 0))
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

/* filelist.f */
rtl/cmd_pkg.sv
rtl/mem_pkg.sv
rtl/scratch_bank.sv
rtl/cmd_parser.sv
rtl/read_merge.sv
rtl/cmd_mem_top.sv
tests/cmd_mem_checker.sv
tests/tb_cmd_mem.sv

/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_cmd_mem \
		-Mdir obj_dir -f filelist.f
	./obj_dir/Vtb_cmd_mem | tee $(LOG)
	grep -q "Test OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
